/* common/gb_pkg.sv */
// shared types and constants for the console system glue
// interrupt indices double as bit positions in IF/IE and as priority order
// addresses are full 16-bit CPU addresses
package gb_pkg;

	typedef logic [15:0] gb_addr_t;
	typedef logic [7:0]  gb_byte_t;

	// ------------------------------
	// interrupts
	localparam int IRQ_COUNT = 5;

	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0, // highest priority
		IRQ_LCD    = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4  // lowest
	} gb_irq_e;

	typedef logic [IRQ_COUNT-1:0] gb_irq_t;

	localparam gb_byte_t IRQ_VEC_BASE = 8'h40; // source n at base + 8*n
	localparam gb_byte_t IRQ_VEC_NONE = 8'h55; // nothing pending

	// ------------------------------
	// work RAM banking
	localparam int WRAM_BANK_BITS  = 3;
	localparam int WRAM_BANK_RESET = 1;

	// ------------------------------
	// io register addresses
	localparam gb_addr_t ADDR_JOYP = 16'hFF00;
	localparam gb_addr_t ADDR_SB   = 16'hFF01;
	localparam gb_addr_t ADDR_SC   = 16'hFF02;
	localparam gb_addr_t ADDR_IF   = 16'hFF0F;
	localparam gb_addr_t ADDR_BOOT = 16'hFF50;
	localparam gb_addr_t ADDR_SVBK = 16'hFF70;
	localparam gb_addr_t ADDR_IE   = 16'hFFFF;

	localparam gb_byte_t FAST_BOOT_FLAG = 8'h42; // seen by boot code at FF50

	typedef enum logic [3:0] {
		REG_ROM, REG_CRAM, REG_WRAM, REG_HRAM,
		REG_JOYP, REG_SB, REG_SC, REG_IF,
		REG_IE, REG_BOOT, REG_SVBK, REG_NONE
	} gb_region_e;

	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} gb_serial_state_e;

endpackage

/* memory/gb_spram.sv */
// single-port RAM, read data registered (one cycle latency)
// read during write returns the old content; no init
`timescale 1ns/1ps

module gb_spram #(
	parameter int ADDR_BITS = 7
) (
	input  logic                 clk_cpu,
	input  logic [ADDR_BITS-1:0] address,
	input  logic                 wren,
	input  logic [7:0]           data,
	output logic [7:0]           q
);

	logic [7:0] mem [2**ADDR_BITS];

	always_ff @(posedge clk_cpu) begin
		if (wren)
			mem[address] <= data;
		q <= mem[address];
	end

endmodule

/* memory/gb_internal_ram.sv */
// work RAM (32k, 4k banks) and 127-byte high RAM
// D000-DFFF follows the bank register, C000-CFFF is always bank 0
// bank writes are expected gated to colour mode upstream
`timescale 1ns/1ps

module gb_internal_ram
	import gb_pkg::*;
(
	input  logic                      clk_cpu,
	input  logic                      reset,
	input  gb_addr_t                  cpu_addr,
	input  gb_byte_t                  cpu_do,
	input  logic                      wram_wr,
	input  logic                      hram_wr,
	input  logic                      svbk_wr,
	output gb_byte_t                  wram_q,
	output gb_byte_t                  hram_q,
	output logic [WRAM_BANK_BITS-1:0] wram_bank
);

	logic [14:0] wram_addr;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			wram_bank <= WRAM_BANK_BITS'(WRAM_BANK_RESET);
		else if (svbk_wr) begin
			if (cpu_do[WRAM_BANK_BITS-1:0] == '0)
				wram_bank <= WRAM_BANK_BITS'(1); // bank 0 not selectable here
			else
				wram_bank <= cpu_do[WRAM_BANK_BITS-1:0];
		end
	end

	// echo area folds onto the same 8k window
	assign wram_addr = cpu_addr[12] ? {wram_bank, cpu_addr[11:0]} :
	                                  {{WRAM_BANK_BITS{1'b0}}, cpu_addr[11:0]};

	gb_spram #(.ADDR_BITS(15)) u_wram (
		.clk_cpu (clk_cpu),
		.address (wram_addr),
		.wren    (wram_wr),
		.data    (cpu_do),
		.q       (wram_q)
	);

	gb_spram #(.ADDR_BITS(7)) u_hram (
		.clk_cpu (clk_cpu),
		.address (cpu_addr[6:0]),
		.wren    (hram_wr),
		.data    (cpu_do),
		.q       (hram_q)
	);

endmodule

/* logic/gb_bus_ctrl.sv */
// address decode, write strobes and registered read data
// cpu_di is valid the cycle after cpu_rd/irq_ack and holds until the next read
// rd and wr never high together; unmapped or dropped addresses read FF
`timescale 1ns/1ps

module gb_bus_ctrl
	import gb_pkg::*;
(
	input  logic                      clk_cpu,
	input  logic                      reset,
	input  logic                      is_gbc,
	input  logic                      fast_boot,
	input  gb_addr_t                  cpu_addr,
	input  gb_byte_t                  cpu_do,
	input  logic                      cpu_rd,
	input  logic                      cpu_wr,
	input  logic                      irq_ack,
	input  gb_byte_t                  cart_do,
	input  gb_byte_t                  boot_do,
	input  gb_byte_t                  joyp_q,
	input  gb_byte_t                  sc_q,
	input  gb_irq_t                   if_q,
	input  gb_irq_t                   ie_q,
	input  gb_byte_t                  irq_vec,
	input  logic [WRAM_BANK_BITS-1:0] wram_bank,
	input  gb_byte_t                  wram_q,
	input  gb_byte_t                  hram_q,
	output gb_byte_t                  cpu_di,
	output logic                      joyp_wr,
	output logic                      sc_wr,
	output logic                      if_wr,
	output logic                      ie_wr,
	output logic                      svbk_wr,
	output logic                      wram_wr,
	output logic                      hram_wr,
	output gb_addr_t                  cart_addr,
	output logic                      cart_rd,
	output logic                      cart_wr,
	output gb_byte_t                  cart_di,
	output logic [11:0]               boot_addr
);

	gb_region_e region;
	gb_region_e rd_region; // source of the pending read
	logic       rd_fresh;  // first cycle after a strobe
	gb_byte_t   rd_val;
	gb_byte_t   read_val;
	gb_byte_t   rom_val;
	logic       boot_en;   // boot overlay active
	logic       boot_hit;

	// ------------------------------
	// address decode
	always_comb begin
		if (!cpu_addr[15])                        region = REG_ROM;
		else if (cpu_addr[15:13] == 3'b101)       region = REG_CRAM;
		else if (cpu_addr[15:14] == 2'b11 && cpu_addr[15:8] != 8'hFF)
			region = REG_WRAM;                       // C000-FEFF incl. echo
		else if (cpu_addr == ADDR_IE)             region = REG_IE;
		else if (cpu_addr[15:7] == 9'h1FF)        region = REG_HRAM; // FF80-FFFE
		else if (cpu_addr == ADDR_JOYP)           region = REG_JOYP;
		else if (cpu_addr == ADDR_SB)             region = REG_SB;
		else if (cpu_addr == ADDR_SC)             region = REG_SC;
		else if (cpu_addr == ADDR_IF)             region = REG_IF;
		else if (cpu_addr == ADDR_BOOT)           region = REG_BOOT;
		else if (cpu_addr == ADDR_SVBK)           region = REG_SVBK;
		else                                      region = REG_NONE;
	end

	// write strobes
	assign joyp_wr = cpu_wr && region == REG_JOYP;
	assign sc_wr   = cpu_wr && region == REG_SC;
	assign if_wr   = cpu_wr && region == REG_IF;
	assign ie_wr   = cpu_wr && region == REG_IE;
	assign svbk_wr = cpu_wr && region == REG_SVBK && is_gbc; // colour mode only
	assign wram_wr = cpu_wr && region == REG_WRAM;
	assign hram_wr = cpu_wr && region == REG_HRAM;

	// ------------------------------
	// boot overlay and cartridge
	always_ff @(posedge clk_cpu) begin
		if (reset)
			boot_en <= 1'b1;
		else if (cpu_wr && region == REG_BOOT) begin
			if ((is_gbc && cpu_do == 8'h11) || (!is_gbc && cpu_do[0]))
				boot_en <= 1'b0; // one-way until reset
		end
	end

	// 0000-00FF always, 0200-08FF in colour mode; header 0100-01FF stays cart
	assign boot_hit = boot_en && (cpu_addr[15:8] == 8'h00 ||
		(is_gbc && cpu_addr >= 16'h0200 && cpu_addr < 16'h0900));
	assign rom_val  = boot_hit ? boot_do : cart_do;

	assign cart_addr = cpu_addr;
	assign cart_di   = cpu_do;
	assign cart_rd   = cpu_rd && (region == REG_ROM || region == REG_CRAM);
	assign cart_wr   = cpu_wr && (region == REG_ROM || region == REG_CRAM);
	assign boot_addr = cpu_addr[11:0];

	// ------------------------------
	// read data
	always_comb begin
		case (region)
			REG_ROM:  read_val = rom_val;
			REG_CRAM: read_val = cart_do;
			REG_JOYP: read_val = joyp_q;
			REG_SB:   read_val = 8'hFF;      // no shift data kept
			REG_SC:   read_val = sc_q;
			REG_IF:   read_val = {3'b111, if_q};
			REG_IE:   read_val = {3'b000, ie_q};
			REG_BOOT: read_val = (fast_boot && boot_en) ? FAST_BOOT_FLAG : 8'hFF;
			REG_SVBK: read_val = is_gbc ? {{(8-WRAM_BANK_BITS){1'b1}}, wram_bank} : 8'hFF;
			default:  read_val = 8'hFF;      // RAMs come from q next cycle
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_fresh  <= 1'b0;
			rd_region <= REG_NONE;
		end else begin
			rd_fresh <= cpu_rd || irq_ack;
			if (irq_ack)
				rd_region <= REG_NONE; // vector held in rd_val
			else if (cpu_rd)
				rd_region <= region;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (irq_ack)
			rd_val <= irq_vec;
		else if (cpu_rd)
			rd_val <= read_val;
		else if (rd_fresh)
			rd_val <= cpu_di; // freeze RAM q before the address moves on
	end

	assign cpu_di = (rd_fresh && rd_region == REG_WRAM) ? wram_q :
	                (rd_fresh && rd_region == REG_HRAM) ? hram_q : rd_val;

endmodule

/* logic/gb_irq_ctrl.sv */
// interrupt flag/enable registers with fixed priority vectoring
// source pulses are one cycle wide; a cpu write wins over a pulse
// the top pending flag clears in the cycle after irq_ack drops
`timescale 1ns/1ps

module gb_irq_ctrl
	import gb_pkg::*;
(
	input  logic     clk_cpu,
	input  logic     reset,
	input  gb_byte_t cpu_do,
	input  logic     if_wr,
	input  logic     ie_wr,
	input  logic     irq_ack,
	input  logic     vblank_irq,
	input  logic     lcd_irq,
	input  logic     timer_irq,
	input  logic     serial_irq,
	input  logic     joy_irq,
	output gb_irq_t  if_q,
	output gb_irq_t  ie_q,
	output gb_byte_t irq_vec,
	output logic     irq
);

	gb_irq_t if_r;
	gb_irq_t ie_r;
	gb_irq_t pending;
	gb_irq_t src;
	gb_irq_t clr_mask;
	gb_irq_e top_idx;
	logic    top_hit;
	logic    ack_d;

	always_comb begin
		src = '0;
		src[IRQ_VBLANK] = vblank_irq;
		src[IRQ_LCD]    = lcd_irq;
		src[IRQ_TIMER]  = timer_irq;
		src[IRQ_SERIAL] = serial_irq;
		src[IRQ_JOYPAD] = joy_irq;
	end

	assign pending = if_r & ie_r;

	// ------------------------------
	// priority pick, lowest index wins
	always_comb begin
		top_hit = 1'b0;
		top_idx = IRQ_VBLANK;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (pending[i]) begin
				top_hit = 1'b1;
				top_idx = gb_irq_e'(i);
			end
		end
		clr_mask = top_hit ? gb_irq_t'(1) << top_idx : '0;
	end

	assign irq_vec = top_hit ? IRQ_VEC_BASE + {2'b00, top_idx, 3'b000} : IRQ_VEC_NONE;
	assign irq     = |pending;
	assign if_q    = if_r;
	assign ie_q    = ie_r;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ack_d <= 1'b0;
		end else begin
			ack_d <= irq_ack;
			if (if_wr)
				if_r <= cpu_do[IRQ_COUNT-1:0]; // cpu overrides pulses
			else if (ack_d && !irq_ack)
				if_r <= (if_r | src) & ~clr_mask; // falling ack
			else
				if_r <= if_r | src;
			if (ie_wr)
				ie_r <= cpu_do[IRQ_COUNT-1:0];
		end
	end

endmodule

/* logic/gb_joypad.sv */
// joypad select register and matrix read
// joystick bit high = pressed; matrix lines are active low
`timescale 1ns/1ps

module gb_joypad
	import gb_pkg::*;
(
	input  logic     clk_cpu,
	input  logic     reset,
	input  gb_byte_t cpu_do,
	input  logic     joyp_wr,
	input  gb_byte_t joystick,
	output gb_byte_t joyp_q,
	output logic     joy_irq
);

	logic [1:0] sel;              // [0] directions, [1] buttons, low = enabled
	logic [3:0] dir_n;
	logic [3:0] btn_n;
	gb_byte_t   line_d1, line_d2; // history of gated lines

	assign dir_n  = ~joystick[3:0] | {4{sel[0]}}; // right left up down
	assign btn_n  = ~joystick[7:4] | {4{sel[1]}}; // a b select start
	assign joyp_q = {2'b11, sel, dir_n & btn_n};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel     <= 2'b00;
			line_d1 <= 8'hFF;
			line_d2 <= 8'hFF;
			joy_irq <= 1'b0;
		end else begin
			if (joyp_wr)
				sel <= cpu_do[5:4];
			line_d1 <= {btn_n, dir_n};
			line_d2 <= line_d1;
			joy_irq <= |(~line_d1 & line_d2); // any 1->0
		end
	end

endmodule

/* logic/gb_serial.sv */
// serial port without data: a started internal-clock transfer just counts
// 8 bit times of 2**SERIAL_DIV_BITS cycles, then interrupts
// external clock transfers never complete
`timescale 1ns/1ps

module gb_serial
	import gb_pkg::*;
#(
	parameter int SERIAL_DIV_BITS = 9
) (
	input  logic     clk_cpu,
	input  logic     reset,
	input  gb_byte_t cpu_do,
	input  logic     sc_wr,
	output gb_byte_t sc_q,
	output logic     serial_irq
);

	gb_serial_state_e           state;
	logic [SERIAL_DIV_BITS-1:0] div;     // bit-time divider
	logic [2:0]                 bit_cnt; // bits done
	logic                       sc_start;
	logic                       sc_clk;  // 1 = internal clock

	assign sc_q = {sc_start, 6'h3F, sc_clk};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= SER_IDLE;
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			serial_irq <= 1'b0;
			div        <= '0;
			bit_cnt    <= '0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				sc_start <= cpu_do[7];
				sc_clk   <= cpu_do[0];
				div      <= '0;
				bit_cnt  <= '0;
				state    <= (cpu_do[7] && cpu_do[0]) ? SER_SHIFT : SER_IDLE;
			end else if (state == SER_SHIFT) begin
				div <= div + 1'b1;
				if (&div) begin // end of a bit time
					if (bit_cnt == 3'd7) begin
						serial_irq <= 1'b1;
						sc_start   <= 1'b0;
						state      <= SER_IDLE;
					end else
						bit_cnt <= bit_cnt + 3'd1;
				end
			end
		end
	end

endmodule

/* logic/gb_system.sv */
// console system glue around an external CPU bus
// cart_do and boot_do must return combinationally from their addresses
// vblank/lcd/timer requests are one-cycle pulses
`timescale 1ns/1ps

module gb_system
	import gb_pkg::*;
#(
	parameter int SERIAL_DIV_BITS = 9
) (
	input  logic        clk_cpu,
	input  logic        reset,
	input  logic        is_gbc,
	input  logic        fast_boot,
	input  gb_addr_t    cpu_addr,
	input  gb_byte_t    cpu_do,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic        irq_ack,
	output gb_byte_t    cpu_di,
	output logic        irq,
	input  gb_byte_t    joystick,
	input  logic        vblank_irq,
	input  logic        lcd_irq,
	input  logic        timer_irq,
	output gb_addr_t    cart_addr,
	output logic        cart_rd,
	output logic        cart_wr,
	output gb_byte_t    cart_di,
	input  gb_byte_t    cart_do,
	output logic [11:0] boot_addr,
	input  gb_byte_t    boot_do
);

	logic joyp_wr, sc_wr, if_wr, ie_wr, svbk_wr, wram_wr, hram_wr;
	logic serial_irq, joy_irq;
	gb_byte_t joyp_q, sc_q, irq_vec, wram_q, hram_q;
	gb_irq_t  if_q, ie_q;
	logic [WRAM_BANK_BITS-1:0] wram_bank;

	gb_bus_ctrl u_bus (
		.clk_cpu, .reset, .is_gbc, .fast_boot,
		.cpu_addr, .cpu_do, .cpu_rd, .cpu_wr, .irq_ack,
		.cart_do, .boot_do,
		.joyp_q, .sc_q, .if_q, .ie_q, .irq_vec, .wram_bank, .wram_q, .hram_q,
		.cpu_di,
		.joyp_wr, .sc_wr, .if_wr, .ie_wr, .svbk_wr, .wram_wr, .hram_wr,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .boot_addr
	);

	gb_irq_ctrl u_irq (
		.clk_cpu, .reset, .cpu_do, .if_wr, .ie_wr, .irq_ack,
		.vblank_irq, .lcd_irq, .timer_irq, .serial_irq, .joy_irq,
		.if_q, .ie_q, .irq_vec, .irq
	);

	gb_joypad u_joy (
		.clk_cpu, .reset, .cpu_do, .joyp_wr, .joystick,
		.joyp_q, .joy_irq
	);

	gb_serial #(.SERIAL_DIV_BITS(SERIAL_DIV_BITS)) u_serial (
		.clk_cpu, .reset, .cpu_do, .sc_wr,
		.sc_q, .serial_irq
	);

	gb_internal_ram u_ram (
		.clk_cpu, .reset, .cpu_addr, .cpu_do,
		.wram_wr, .hram_wr, .svbk_wr,
		.wram_q, .hram_q, .wram_bank
	);

endmodule

/* tb/tb_clock.sv */
// clock and reset source for the testbench
// reset drops 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_cpu,
	output logic reset
);

	initial begin
		clk_cpu = 1'b0;
		forever #(PERIOD_NS / 2) clk_cpu = ~clk_cpu;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_cpu);
		#1;
		reset = 1'b0; // off the edge, like all tb drives
	end

endmodule

/* tb/gb_irq_checker.sv */
// assertions on the interrupt controller, bound into gb_irq_ctrl
// a cpu write to IF may change any number of flags, so it is excluded
`timescale 1ns/1ps

module gb_irq_checker
	import gb_pkg::*;
(
	input logic     clk_cpu,
	input logic     reset,
	input logic     if_wr,
	input logic     irq_ack,
	input logic     vblank_irq,
	input logic     lcd_irq,
	input logic     timer_irq,
	input logic     serial_irq,
	input logic     joy_irq,
	input gb_irq_t  if_q,
	input gb_irq_t  ie_q,
	input gb_byte_t irq_vec,
	input logic     irq
);

	logic       any_src; // some request this cycle
	gb_byte_t   vec_off; // vector minus the base
	logic [2:0] vec_idx; // source the vector names
	gb_irq_t    pend;
	gb_irq_t    higher;  // sources ahead of vec_idx

	assign any_src = vblank_irq || lcd_irq || timer_irq || serial_irq || joy_irq;
	assign vec_off = irq_vec - IRQ_VEC_BASE;
	assign vec_idx = vec_off[5:3];
	assign pend    = if_q & ie_q;
	assign higher  = (gb_irq_t'(1) << vec_idx) - gb_irq_t'(1);

	// irq high exactly when the vector names the first pending enabled source
	a_irq_level: assert property (@(posedge clk_cpu) disable iff (reset)
		irq ? (vec_off[2:0] == 3'd0 && vec_off < 8'(IRQ_COUNT * 8) &&
		       pend[vec_idx] && (pend & higher) == '0)
		    : (irq_vec == IRQ_VEC_NONE && pend == '0))
		else $error("irq and vector disagree with the pending enabled flags");

	// falling ack, flags drop by one at most
	a_ack_one: assert property (@(posedge clk_cpu) disable iff (reset)
		($past(irq_ack) && !irq_ack && !if_wr) |=> $countones($past(if_q) & ~if_q) <= 1)
		else $error("acknowledge cleared more than one flag");

	a_reset_zero: assert property (@(posedge clk_cpu)
		$fell(reset) |-> (if_q == '0 && ie_q == '0))
		else $error("IF or IE not zero after reset");

	// no request, no write -> zero flags stay zero
	a_idle_zero: assert property (@(posedge clk_cpu) disable iff (reset)
		(if_q == '0 && !any_src && !if_wr) |=> if_q == '0)
		else $error("IF set without a request");

endmodule

/* tb/gb_tb.sv */
// testbench top: replays tb/gb_golden.mem against the system glue
// record = op addr[23:8] data[7:0], op in [27:24] or [31:28]; op 0 ends the list
// cart ROM answers lo^hi address byte, boot ROM the inverted low byte
// must be run from the project root (relative data path)
`timescale 1ns/1ps

module gb_tb
	import gb_pkg::*;
();

	localparam int DIV_BITS = 4;  // short serial bit time
	localparam int MAX_RECS = 64;

	logic        clk_cpu;
	logic        reset;
	logic        is_gbc;
	logic        fast_boot;
	gb_addr_t    cpu_addr;
	gb_byte_t    cpu_do;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        irq_ack;
	gb_byte_t    cpu_di;
	logic        irq;
	gb_byte_t    joystick;
	logic        vblank_irq;
	logic        lcd_irq;
	logic        timer_irq;
	gb_addr_t    cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	gb_byte_t    cart_di;
	gb_byte_t    cart_do;
	logic [11:0] boot_addr;
	gb_byte_t    boot_do;

	logic [31:0] recs [MAX_RECS];
	int          n_recs;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          limit  = 0; // 0 until the record count is known

	tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_clk (
		.clk_cpu (clk_cpu),
		.reset   (reset)
	);

	gb_system #(.SERIAL_DIV_BITS(DIV_BITS)) DUT (
		.clk_cpu, .reset, .is_gbc, .fast_boot,
		.cpu_addr, .cpu_do, .cpu_rd, .cpu_wr, .irq_ack,
		.cpu_di, .irq, .joystick, .vblank_irq, .lcd_irq, .timer_irq,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .cart_do,
		.boot_addr, .boot_do
	);

	bind gb_irq_ctrl gb_irq_checker u_irq_chk (.*);

	// rom models, combinational
	assign cart_do = cart_addr[7:0] ^ cart_addr[15:8];
	assign boot_do = ~boot_addr[7:0];

	// ------------------------------
	// run limit
	always @(posedge clk_cpu) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("run did not finish within %0d cycles", limit);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ROM below 8000, cart RAM A000-BFFF
	function automatic logic is_cart_addr(input gb_addr_t a);
		return !a[15] || a[15:13] == 3'b101;
	endfunction

	// a record written with eight digits has its op one nibble higher
	function automatic logic [3:0] record_op(input logic [31:0] r);
		return (r[31:28] != 4'h0) ? r[31:28] : r[27:24];
	endfunction

	task automatic report_error(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		errors++;
		$display("[ERROR] %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	// ------------------------------
	// bus cycles
	task automatic write_byte(input gb_addr_t a, input gb_byte_t d);
		@(posedge clk_cpu);
		#1;
		cpu_addr = a;
		cpu_do   = d;
		cpu_wr   = 1'b1;
		@(negedge clk_cpu); // mid strobe cycle
		checks++;
		if (cart_wr !== is_cart_addr(a))
			report_error("cart_wr", {7'd0, cart_wr}, {7'd0, is_cart_addr(a)});
		if (is_cart_addr(a) && cart_di !== d)
			report_error("cart_di", cart_di, d);
		if (is_cart_addr(a) && cart_addr !== a)
			report_error("cart_addr", cart_addr, a);
		@(posedge clk_cpu);
		#1;
		cpu_wr = 1'b0;
	endtask

	task automatic read_byte(input gb_addr_t a, output gb_byte_t d);
		@(posedge clk_cpu);
		#1;
		cpu_addr = a;
		cpu_rd   = 1'b1;
		@(negedge clk_cpu);
		checks++;
		if (cart_rd !== is_cart_addr(a))
			report_error("cart_rd", {7'd0, cart_rd}, {7'd0, is_cart_addr(a)});
		if (is_cart_addr(a) && cart_addr !== a)
			report_error("cart_addr", cart_addr, a);
		if (boot_addr !== a[11:0])
			report_error("boot_addr", {4'd0, boot_addr}, {4'd0, a[11:0]});
		@(posedge clk_cpu);
		#1;
		cpu_rd = 1'b0;
		@(negedge clk_cpu); // data valid the cycle after the strobe
		d = cpu_di;
	endtask

	task automatic compare_read(input gb_addr_t a, input gb_byte_t exp);
		gb_byte_t got;
		read_byte(a, got);
		checks++;
		if (got !== exp)
			report_error($sformatf("cpu_di @%04h", a), got, exp);
	endtask

	task automatic ack_vector(input gb_byte_t exp);
		@(posedge clk_cpu);
		#1;
		irq_ack = 1'b1;
		@(posedge clk_cpu);
		#1;
		irq_ack = 1'b0;
		@(negedge clk_cpu);
		checks++;
		if (cpu_di !== exp)
			report_error("cpu_di (vector)", cpu_di, exp);
	endtask

	// addr 0000: {fast_boot, is_gbc}, anything else: joystick
	task automatic set_inputs(input gb_addr_t sel, input gb_byte_t d);
		@(posedge clk_cpu);
		#1;
		if (sel == 16'h0000) begin
			is_gbc    = d[0];
			fast_boot = d[1];
		end else
			joystick = d;
	endtask

	task automatic pulse_irqs(input logic [2:0] req);
		@(posedge clk_cpu);
		#1;
		vblank_irq = req[0];
		lcd_irq    = req[1];
		timer_irq  = req[2];
		@(posedge clk_cpu);
		#1;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
	endtask

	task automatic irq_level_is(input logic exp);
		@(negedge clk_cpu);
		checks++;
		if (irq !== exp)
			report_error("irq", {7'd0, irq}, {7'd0, exp});
	endtask

	// poll IF until the bit shows up or the cycle budget runs out
	task automatic wait_if_bit(input int bit_idx, input int max_cycles);
		int       start;
		gb_byte_t flags;
		start = cycles;
		flags = 8'h00;
		while (!flags[bit_idx] && cycles - start <= max_cycles)
			read_byte(ADDR_IF, flags);
		checks++;
		if (!flags[bit_idx]) begin
			errors++;
			$display("IF bit %0d was not set within %0d cycles", bit_idx, max_cycles);
		end
	endtask

	// ------------------------------
	// main sequence
	initial begin
		logic [3:0] op;
		gb_addr_t   a;
		gb_byte_t   d;
		is_gbc     = 1'b0;
		fast_boot  = 1'b0;
		cpu_addr   = '0;
		cpu_do     = '0;
		cpu_rd     = 1'b0;
		cpu_wr     = 1'b0;
		irq_ack    = 1'b0;
		joystick   = '0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		for (int i = 0; i < MAX_RECS; i++)
			recs[i] = '0;
		$readmemh("tb/gb_golden.mem", recs);
		n_recs = 0;
		while (n_recs < MAX_RECS && record_op(recs[n_recs]) != 4'h0)
			n_recs++;
		if (n_recs == 0) begin
			errors++;
			$display("no records found in tb/gb_golden.mem");
		end
		limit = n_recs * 16 + 12 * (2 ** DIV_BITS);
		@(negedge reset);
		for (int i = 0; i < n_recs; i++) begin
			op = record_op(recs[i]);
			a  = recs[i][23:8];
			d  = recs[i][7:0];
			case (op)
				4'h1: write_byte(a, d);
				4'h2: compare_read(a, d);
				4'h3: compare_read(a, a[7:0] ^ a[15:8]); // cart rule
				4'h4: compare_read(a, ~a[7:0]);          // boot rule
				4'h5: set_inputs(a, d);
				4'h6: ack_vector(d);
				4'h7: pulse_irqs(d[2:0]);
				4'h8: wait_if_bit(int'(d[2:0]), int'(a));
				4'h9: irq_level_is(d[0]);
				default: begin
					errors++;
					$display("record %0d has unknown operation %0h", i, op);
				end
			endcase
		end
		repeat (2) @(posedge clk_cpu);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* tb/gb_golden.mem */
// columns: op(1 hex) addr(4 hex) data(2 hex); ops 1 wr, 2 rd+expect, 3 rd cart, 4 rd boot
// 5 set inputs (addr 0: mode, else joystick), 6 ack+vector, 7 pulse, 8 wait IF bit, 9 irq, 0 end
// boot overlay and cartridge, colour mode with fast boot
50000003
40000000
400A500
30010000
40023400
2FF5042
1FF5011
30000000
2FF50FF
1200005A
// work RAM banks and high RAM
1FF7002
1D000A2
1FF7003
1D000B3
1C000C0
2D000B3
1FF7002
2D000A2
2C000C0
1FF7000
2FF70F9
1FF803C
2FF803C
1FFFEE7
2FFFEE7
// DMG mode ignores the bank register
50000000
1FF7005
2FF70FF
50000001
2FF70F9
// joypad
1FF0020
50001021
2FF00EE
1FF0010
2FF00DD
1FF0F00
500010A1
80001004
// interrupt priority
1FF0F00
1FFFF1F
90000000
70000005
90000001
60000040
60000050
2FF0FE0
90000000
// serial
1FF0281
80009003
2FF027F
00000000

/* list.f */
common/gb_pkg.sv
memory/gb_spram.sv
memory/gb_internal_ram.sv
logic/gb_bus_ctrl.sv
logic/gb_irq_ctrl.sv
logic/gb_joypad.sv
logic/gb_serial.sv
logic/gb_system.sv
tb/tb_clock.sv
tb/gb_irq_checker.sv
tb/gb_tb.sv

/* Makefile */
# Verilator flow for the console system glue testbench
TOP := gb_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# pass only if the run prints the pass message
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o gb_sim
	@out=$$(./obj_dir/gb_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
